// ==== include/nx_cfg.svh ====
// Build-time sizes of the mesh node, included by the package and by RTL sized from them
`ifndef NX_CFG_SVH
`define NX_CFG_SVH

// Width of one mesh coordinate (row or column)
`define NX_COORD_W 4

// RAM geometry shared by instruction and data memories
`define NX_RAM_AW 6
`define NX_RAM_DEPTH 64

// Data word carried by messages and held in the data RAM
`define NX_DATA_W 16

// Full message width on every stream
`define NX_MSG_W 32

`endif

// ==== src/nx_pkg.sv ====
// Shared node types: identifiers, message layout, instruction layout and face indices
`include "nx_cfg.svh"

package nx_pkg;

// Mesh position of a node
typedef struct packed {
    logic [`NX_COORD_W-1:0] row;
    logic [`NX_COORD_W-1:0] column;
} node_id_t;

// Message commands, codes 2 and 3 are reserved
typedef enum logic [1:0] {
    LOAD_INST  = 2'd0,
    STORE_DATA = 2'd1,
    CMD_RSVD_2 = 2'd2,
    CMD_RSVD_3 = 2'd3
} msg_cmd_t;

typedef logic [`NX_DATA_W-1:0] data_word_t;

// Payload bits left after header fields
localparam int MSG_DATA_W = `NX_MSG_W - $bits(node_id_t) - $bits(msg_cmd_t) - `NX_RAM_AW;

// Packed message, target in the top byte
typedef struct packed {
    node_id_t                target;
    msg_cmd_t                command;
    logic [`NX_RAM_AW-1:0]   address;
    logic [MSG_DATA_W-1:0]   data;
} nx_msg_t;

typedef enum logic [1:0] {
    ADD   = 2'd0,
    STORE = 2'd1,
    SEND  = 2'd2,
    HALT  = 2'd3
} inst_op_t;

// Instruction word
// SEND operand holds target row, column and remote address
typedef struct packed {
    inst_op_t               op;
    logic [`NX_DATA_W-3:0]  operand;
} inst_t;

// Face index
typedef enum logic [1:0] {
    NORTH = 2'd0,
    EAST  = 2'd1,
    SOUTH = 2'd2,
    WEST  = 2'd3
} dir_e;

endpackage : nx_pkg

// ==== src/nx_ram_if.sv ====
// One RAM port as a bundle, sized by payload type, between a port owner and the memory
`include "nx_cfg.svh"

interface nx_ram_if #(
    parameter type T = logic [`NX_DATA_W-1:0]
) ();

// Port signals
logic [`NX_RAM_AW-1:0] addr;
T                      wr_data;
logic                  wr_en;
logic                  rd_en;
// Valid one cycle after rd_en
T                      rd_data;

// Side that issues accesses
modport owner (output addr, output wr_data, output wr_en, output rd_en, input rd_data);

// Side that holds the array
modport mem (input addr, input wr_data, input wr_en, input rd_en, output rd_data);

endinterface : nx_ram_if

// ==== src/nx_ram.sv ====
// Dual-port synchronous RAM for any payload type, port A write-only and port B read/write
`include "nx_cfg.svh"

module nx_ram #(
      parameter type T     = logic [`NX_DATA_W-1:0]
    , parameter int  DEPTH = `NX_RAM_DEPTH
) (
      input  logic   i_clk
    , nx_ram_if.mem  port_a
    , nx_ram_if.mem  port_b
);

// Storage array
T mem_q [DEPTH];

// Port B read register
T rd_b_q;

always_ff @(posedge i_clk) begin
    // Port A writes first so port B wins an address clash
    if (port_a.wr_en) begin
        mem_q[port_a.addr] <= port_a.wr_data;
    end
    if (port_b.wr_en) begin
        mem_q[port_b.addr] <= port_b.wr_data;
    end else if (port_b.rd_en) begin
        rd_b_q <= mem_q[port_b.addr];
    end
end

// Port A never returns data
assign port_a.rd_data = '0;
assign port_b.rd_data = rd_b_q;

endmodule : nx_ram

// ==== src/nx_node_decoder.sv ====
// Inbound stage of a node: picks one face per cycle, writes local RAMs, registers bypass traffic
module nx_node_decoder
import nx_pkg::*;
(
      input  logic     i_clk
    , input  logic     i_arst_n
    // Control
    , input  node_id_t i_node_id
    , output logic     o_idle
    // Inbound faces
    , input  nx_msg_t  i_inbound_data [4]
    , input  logic     i_inbound_valid [4]
    , output logic     o_inbound_ready [4]
    // Bypass stream
    , output nx_msg_t  o_bypass_data
    , output logic     o_bypass_valid
    , input  logic     i_bypass_ready
    // RAM port A of each memory
    , nx_ram_if.owner  inst_ram
    , nx_ram_if.owner  data_ram
);

// ========================================
// Round-robin grant
// ========================================

logic [1:0] last_q;
logic [1:0] cand;
logic [1:0] grant_idx;
logic       grant_found;

// Search starts at the face after the last grant
always_comb begin
    grant_found = 1'b0;
    grant_idx   = last_q;
    cand        = last_q;
    for (int i = 1; i <= 4; i++) begin
        cand = last_q + 2'(i);
        if (!grant_found && i_inbound_valid[cand]) begin
            grant_found = 1'b1;
            grant_idx   = cand;
        end
    end
end

logic    bypass_valid_q;
nx_msg_t bypass_data_q;
nx_msg_t grant_msg;
logic    accept;
logic    is_local;
logic    is_reserved;

assign grant_msg   = i_inbound_data[grant_idx];
assign accept      = grant_found && !bypass_valid_q;
assign is_local    = (grant_msg.target == i_node_id);
assign is_reserved = (grant_msg.command != LOAD_INST) && (grant_msg.command != STORE_DATA);

// All faces ready while nothing waits, else only the granted one
always_comb begin
    for (int f = 0; f < 4; f++) begin
        o_inbound_ready[f] = !bypass_valid_q && (!grant_found || (grant_idx == 2'(f)));
    end
end

// ========================================
// Local RAM writes on the accept edge
// ========================================

assign inst_ram.addr    = grant_msg.address;
assign inst_ram.wr_data = grant_msg.data;
assign inst_ram.wr_en   = accept && is_local && (grant_msg.command == LOAD_INST);
assign inst_ram.rd_en   = 1'b0;

assign data_ram.addr    = grant_msg.address;
assign data_ram.wr_data = grant_msg.data;
assign data_ram.wr_en   = accept && is_local && (grant_msg.command == STORE_DATA);
assign data_ram.rd_en   = 1'b0;

// ========================================
// Bypass register
// ========================================

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        // North gets first look after reset
        last_q         <= 2'd3;
        bypass_valid_q <= 1'b0;
    end else begin
        if (accept) begin
            last_q <= grant_idx;
        end
        // Reserved commands fall through and are dropped
        if (accept && !is_local && !is_reserved) begin
            bypass_valid_q <= 1'b1;
        end else if (i_bypass_ready) begin
            bypass_valid_q <= 1'b0;
        end
    end
end

always_ff @(posedge i_clk) begin
    if (accept) begin
        bypass_data_q <= grant_msg;
    end
end

assign o_bypass_data  = bypass_data_q;
assign o_bypass_valid = bypass_valid_q;
assign o_idle         = !bypass_valid_q;

endmodule : nx_node_decoder

// ==== src/nx_stream_arbiter.sv ====
// Combinational fixed-priority merge of two message streams, input 0 winning ties
module nx_stream_arbiter
import nx_pkg::*;
(
    // Candidate streams, lower index wins
      input  nx_msg_t i_inbound_data [2]
    , input  logic    i_inbound_valid [2]
    , output logic    o_inbound_ready [2]
    // Merged stream
    , output nx_msg_t o_outbound_data
    , output logic    o_outbound_valid
    , input  logic    i_outbound_ready
);

// ========================================
// Winner selection
// ========================================

// Index of the stream being forwarded
logic sel;

// Walk downward so the lowest valid index is left in sel
always_comb begin
    sel = 1'b1;
    for (int i = 1; i >= 0; i--) begin
        if (i_inbound_valid[i]) begin
            sel = 1'(i);
        end
    end
end

// ========================================
// Forwarding
// ========================================

// Winner's data and valid pass straight through
assign o_outbound_data  = i_inbound_data[sel];
assign o_outbound_valid = i_inbound_valid[sel];

// Loser is held off until the winner drains
always_comb begin
    for (int i = 0; i < 2; i++) begin
        o_inbound_ready[i] = i_outbound_ready && (sel == 1'(i));
    end
end

endmodule : nx_stream_arbiter

// ==== src/nx_node_distributor.sv ====
// Outbound stage of a node: X-then-Y face selection and one registered slot per face
module nx_node_distributor
import nx_pkg::*;
(
      input  logic     i_clk
    , input  logic     i_arst_n
    // Control
    , input  node_id_t i_node_id
    , output logic     o_idle
    // Merged stream from the arbiter
    , input  nx_msg_t  i_outbound_data
    , input  logic     i_outbound_valid
    , output logic     o_outbound_ready
    // External faces
    , output nx_msg_t  o_external_data [4]
    , output logic     o_external_valid [4]
    , input  logic     i_external_ready [4]
);

// ========================================
// Route selection
// ========================================

dir_e route;

// Column first, then row
always_comb begin
    if (i_outbound_data.target.column > i_node_id.column) begin
        route = EAST;
    end else if (i_outbound_data.target.column < i_node_id.column) begin
        route = WEST;
    end else if (i_outbound_data.target.row > i_node_id.row) begin
        route = SOUTH;
    end else begin
        // Smaller row, or addressed to this node
        route = NORTH;
    end
end

logic    slot_valid_q [4];
nx_msg_t slot_data_q [4];
logic    slot_free [4];
logic    accept;

assign o_outbound_ready = slot_free[route];
assign accept           = i_outbound_valid && o_outbound_ready;

// ========================================
// Per-face output slots
// ========================================

for (genvar f = 0; f < 4; f++) begin : g_face
    // Empty, or draining this cycle
    assign slot_free[f] = !slot_valid_q[f] || i_external_ready[f];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            slot_valid_q[f] <= 1'b0;
        end else if (accept && (route == dir_e'(f))) begin
            slot_valid_q[f] <= 1'b1;
        end else if (i_external_ready[f]) begin
            slot_valid_q[f] <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept && (route == dir_e'(f))) begin
            slot_data_q[f] <= i_outbound_data;
        end
    end

    assign o_external_data[f]  = slot_data_q[f];
    assign o_external_valid[f] = slot_valid_q[f];
end

// Quiet once every slot is empty
assign o_idle = !(slot_valid_q[0] || slot_valid_q[1] || slot_valid_q[2] || slot_valid_q[3]);

endmodule : nx_node_distributor

// ==== src/nx_node_core.sv ====
// Tiny accumulator core: starts on trigger, runs ADD, STORE, SEND and HALT from instruction RAM
`include "nx_cfg.svh"

module nx_node_core
import nx_pkg::*;
(
      input  logic    i_clk
    , input  logic    i_arst_n
    // Control
    , input  logic    i_trigger
    , output logic    o_idle
    // RAM port B of each memory
    , nx_ram_if.owner inst_ram
    , nx_ram_if.owner data_ram
    // Send stream towards the arbiter
    , output nx_msg_t o_send_data
    , output logic    o_send_valid
    , input  logic    i_send_ready
);

// Top bit of the target id inside a SEND operand
localparam int SEND_ID_MSB = 2 * `NX_COORD_W + `NX_RAM_AW - 1;

typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_FETCH_WAIT,
    ST_DECODE,
    ST_OPERAND,
    ST_OPERAND_WAIT,
    ST_EXECUTE
} core_state_e;

core_state_e           state_q;
logic [`NX_RAM_AW-1:0] pc_q;
data_word_t            acc_q;
inst_t                 inst_q;
data_word_t            operand_q;

// ========================================
// RAM accesses
// ========================================

// Instruction fetch only
assign inst_ram.addr    = pc_q;
assign inst_ram.wr_data = '0;
assign inst_ram.wr_en   = 1'b0;
assign inst_ram.rd_en   = (state_q == ST_FETCH);

// Operand read for ADD, write-back for STORE
assign data_ram.addr    = inst_q.operand[`NX_RAM_AW-1:0];
assign data_ram.wr_data = acc_q;
assign data_ram.wr_en   = (state_q == ST_EXECUTE) && (inst_q.op == STORE);
assign data_ram.rd_en   = (state_q == ST_OPERAND);

// Outbound store message, held stable while SEND waits
always_comb begin
    o_send_data.target  = inst_q.operand[SEND_ID_MSB:`NX_RAM_AW];
    o_send_data.command = STORE_DATA;
    o_send_data.address = inst_q.operand[`NX_RAM_AW-1:0];
    o_send_data.data    = acc_q;
end

assign o_send_valid = (state_q == ST_EXECUTE) && (inst_q.op == SEND);

// ========================================
// Sequencer
// ========================================

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        state_q <= ST_IDLE;
        pc_q    <= '0;
        acc_q   <= '0;
    end else begin
        case (state_q)
            ST_IDLE: begin
                // Fresh run from address 0
                if (i_trigger) begin
                    pc_q    <= '0;
                    acc_q   <= '0;
                    state_q <= ST_FETCH;
                end
            end
            ST_FETCH:      state_q <= ST_FETCH_WAIT;
            ST_FETCH_WAIT: state_q <= ST_DECODE;
            ST_DECODE: begin
                case (inst_q.op)
                    ADD:     state_q <= ST_OPERAND;
                    HALT:    state_q <= ST_IDLE;
                    default: state_q <= ST_EXECUTE;
                endcase
            end
            ST_OPERAND:      state_q <= ST_OPERAND_WAIT;
            ST_OPERAND_WAIT: state_q <= ST_EXECUTE;
            ST_EXECUTE: begin
                if (inst_q.op == ADD) begin
                    acc_q <= acc_q + operand_q;
                end
                // SEND stalls here under back-pressure
                if ((inst_q.op != SEND) || i_send_ready) begin
                    pc_q    <= pc_q + 1'b1;
                    state_q <= ST_FETCH;
                end
            end
            default: state_q <= ST_IDLE;
        endcase
    end
end

// Captured read data
always_ff @(posedge i_clk) begin
    if (state_q == ST_FETCH_WAIT) begin
        inst_q <= inst_ram.rd_data;
    end
    if (state_q == ST_OPERAND_WAIT) begin
        operand_q <= data_ram.rd_data;
    end
end

assign o_idle = (state_q == ST_IDLE);

endmodule : nx_node_core

// ==== src/nx_node.sv ====
// Mesh node top level: two RAMs, inbound decoder, merge arbiter, outbound distributor and core
`include "nx_cfg.svh"

module nx_node
import nx_pkg::*;
(
      input  logic     i_clk
    , input  logic     i_arst_n
    // Control
    , input  node_id_t i_node_id
    , input  logic     i_trigger
    , input  logic     i_idle
    , output logic     o_idle
    // Inbound faces
    , input  nx_msg_t  i_inbound_data [4]
    , input  logic     i_inbound_valid [4]
    , output logic     o_inbound_ready [4]
    // Outbound faces
    , output nx_msg_t  o_outbound_data [4]
    , output logic     o_outbound_valid [4]
    , input  logic     i_outbound_ready [4]
);

// ========================================
// Memories
// ========================================

// Port A from decoder, port B from core
nx_ram_if #(.T(inst_t))      inst_port_a ();
nx_ram_if #(.T(inst_t))      inst_port_b ();
nx_ram_if #(.T(data_word_t)) data_port_a ();
nx_ram_if #(.T(data_word_t)) data_port_b ();

nx_ram #(
      .T      ( inst_t        )
    , .DEPTH  ( `NX_RAM_DEPTH )
) u_inst_ram (
      .i_clk  ( i_clk         )
    , .port_a ( inst_port_a   )
    , .port_b ( inst_port_b   )
);

nx_ram #(
      .T      ( data_word_t   )
    , .DEPTH  ( `NX_RAM_DEPTH )
) u_data_ram (
      .i_clk  ( i_clk         )
    , .port_a ( data_port_a   )
    , .port_b ( data_port_b   )
);

// ========================================
// Message path
// ========================================

// Merge inputs: 0 is bypass, 1 is core send
nx_msg_t comb_data [2];
logic    comb_valid [2];
logic    comb_ready [2];

nx_msg_t merged_data;
logic    merged_valid;
logic    merged_ready;
logic    decd_idle;
logic    dist_idle;
logic    core_idle;

nx_node_decoder u_decoder (
      .i_clk, .i_arst_n, .i_node_id
    , .o_idle          ( decd_idle       )
    , .i_inbound_data  ( i_inbound_data  )
    , .i_inbound_valid ( i_inbound_valid )
    , .o_inbound_ready ( o_inbound_ready )
    , .o_bypass_data   ( comb_data[0]    )
    , .o_bypass_valid  ( comb_valid[0]   )
    , .i_bypass_ready  ( comb_ready[0]   )
    , .inst_ram        ( inst_port_a     )
    , .data_ram        ( data_port_a     )
);

nx_stream_arbiter u_arbiter (
      .i_inbound_data   ( comb_data    )
    , .i_inbound_valid  ( comb_valid   )
    , .o_inbound_ready  ( comb_ready   )
    , .o_outbound_data  ( merged_data  )
    , .o_outbound_valid ( merged_valid )
    , .i_outbound_ready ( merged_ready )
);

nx_node_distributor u_distributor (
      .i_clk, .i_arst_n, .i_node_id
    , .o_idle           ( dist_idle        )
    , .i_outbound_data  ( merged_data      )
    , .i_outbound_valid ( merged_valid     )
    , .o_outbound_ready ( merged_ready     )
    , .o_external_data  ( o_outbound_data  )
    , .o_external_valid ( o_outbound_valid )
    , .i_external_ready ( i_outbound_ready )
);

// ========================================
// Core and idle
// ========================================

nx_node_core u_core (
      .i_clk, .i_arst_n, .i_trigger
    , .o_idle       ( core_idle     )
    , .inst_ram     ( inst_port_b   )
    , .data_ram     ( data_port_b   )
    , .o_send_data  ( comb_data[1]  )
    , .o_send_valid ( comb_valid[1] )
    , .i_send_ready ( comb_ready[1] )
);

// Node is quiet only when every part and the neighbours agree
assign o_idle = &{i_idle, decd_idle, dist_idle, core_idle};

endmodule : nx_node

// ==== testbench/nx_node_assert.sv ====
// Concurrent handshake and reset checks bound into the mesh node by the testbench
module nx_node_assert
import nx_pkg::*;
(
      input  logic    i_clk
    , input  logic    i_arst_n
    // Outbound faces
    , input  nx_msg_t i_out_data [4]
    , input  logic    i_out_valid [4]
    , input  logic    i_out_ready [4]
    // Inbound ready
    , input  logic    i_in_ready [4]
    // Core send stream inside the node
    , input  nx_msg_t i_send_data
    , input  logic    i_send_valid
    , input  logic    i_send_ready
);

timeunit 1ns;
timeprecision 1ns;

// Count of failed assertions
int fail_count = 0;

// ========================================
// Per-face properties
// ========================================

for (genvar f = 0; f < 4; f++) begin : g_face
    // Stalled outbound message keeps valid and data
    a_out_hold : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_out_valid[f] && !i_out_ready[f]) |=> (i_out_valid[f] && $stable(i_out_data[f])))
        else begin
            $error("outbound face %0d dropped or changed a stalled message", f);
            fail_count++;
        end

    // Quiet faces while in reset
    a_out_rst : assert property (@(posedge i_clk)
        !i_arst_n |-> !i_out_valid[f])
        else begin
            $error("outbound face %0d valid during reset", f);
            fail_count++;
        end

    // Intake open in reset
    a_in_rst : assert property (@(posedge i_clk)
        !i_arst_n |-> i_in_ready[f])
        else begin
            $error("inbound face %0d not ready during reset", f);
            fail_count++;
        end
end

// SEND held until the arbiter takes it
a_send_hold : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_send_valid && !i_send_ready) |=> (i_send_valid && $stable(i_send_data)))
    else begin
        $error("core send message dropped or changed while stalled");
        fail_count++;
    end

endmodule : nx_node_assert

// ==== testbench/nx_node_checker.sv ====
// Node output monitor: loads per-face expected messages from the pattern file, compares transfers
module nx_node_checker
import nx_pkg::*;
(
      input  logic    i_clk
    , input  logic    i_arst_n
    // Idle pair
    , input  logic    i_env_idle
    , input  logic    i_node_idle
    // Outbound faces of the DUT
    , input  nx_msg_t i_out_data [4]
    , input  logic    i_out_valid [4]
    , input  logic    i_out_ready [4]
    // Test closing from the driver
    , input  logic    i_test_done
    , input  int      i_test_num
    // Running totals
    , output int      o_errors
    , output int      o_checks
);

timeunit 1ns;
timeprecision 1ns;

localparam int RECS = 64;

logic [39:0] recs [RECS];

// Per-face expectation queues, head and tail pointers
nx_msg_t exp_msg [4][RECS];
int      exp_test [4][RECS];
int      head [4];
int      tail [4];

int errors = 0;
int checks = 0;

assign o_errors = errors;
assign o_checks = checks;

// ========================================
// Expectation loading
// ========================================

initial begin
    int   idx;
    int   test;
    int   face;
    logic more;
    for (int i = 0; i < RECS; i++) begin
        recs[i] = '0;
    end
    for (int f = 0; f < 4; f++) begin
        head[f] = 0;
        tail[f] = 0;
    end
    $readmemh("testbench/nx_node_patterns.hex", recs);
    idx  = 0;
    test = 1;
    more = 1'b1;
    while (more && (idx < RECS)) begin
        case (recs[idx][39:36])
            4'h0: more = 1'b0;
            4'h4: begin
                face                       = int'(recs[idx][33:32]);
                exp_msg[face][tail[face]]  = recs[idx][31:0];
                exp_test[face][tail[face]] = test;
                tail[face]                 = tail[face] + 1;
            end
            // Test boundary
            4'h5: test = test + 1;
            default: ;
        endcase
        idx = idx + 1;
    end
end

// ========================================
// Comparison
// ========================================

always @(posedge i_clk) begin
    if (!i_arst_n) begin
        // Reset state, faces quiet and idle follows the environment
        for (int f = 0; f < 4; f++) begin
            if (i_out_valid[f] !== 1'b0) begin
                $display("ERROR o_outbound_valid[%0d] expected 0x0 got 0x%0h in reset",
                         f, i_out_valid[f]);
                errors = errors + 1;
            end
        end
        if (i_node_idle !== i_env_idle) begin
            $display("ERROR o_idle expected 0x%0h got 0x%0h in reset", i_env_idle, i_node_idle);
            errors = errors + 1;
        end
        checks = checks + 1;
    end else begin
        for (int f = 0; f < 4; f++) begin
            if (i_out_valid[f] && i_out_ready[f]) begin
                checks = checks + 1;
                if (head[f] == tail[f]) begin
                    $display("ERROR o_outbound_valid[%0d] expected 0x0 got 0x1, message 0x%08h",
                             f, i_out_data[f]);
                    errors = errors + 1;
                end else begin
                    if (i_out_data[f] !== exp_msg[f][head[f]]) begin
                        $display("ERROR o_outbound_data[%0d] expected 0x%08h got 0x%08h",
                                 f, exp_msg[f][head[f]], i_out_data[f]);
                        errors = errors + 1;
                    end
                    head[f] = head[f] + 1;
                end
            end
        end
        // Anything still owed by a closed test never came out
        if (i_test_done) begin
            for (int f = 0; f < 4; f++) begin
                while ((head[f] != tail[f]) && (exp_test[f][head[f]] <= i_test_num)) begin
                    $display("Expected message 0x%08h on face %0d in test %0d never appeared",
                             exp_msg[f][head[f]], f, exp_test[f][head[f]]);
                    errors  = errors + 1;
                    head[f] = head[f] + 1;
                end
            end
        end
    end
end

endmodule : nx_node_checker

// ==== testbench/tb_nx_node.sv ====
// Testbench top for the mesh node with clock, reset, pattern-file stimulus, back-pressure and verdict
module tb_nx_node
import nx_pkg::*;
();

timeunit 1ns;
timeprecision 1ns;

localparam int RECS         = 64;
localparam int BUF_DEPTH    = 64;
localparam int IDLE_TIMEOUT = 2000;

logic     clk    = 1'b0;
logic     arst_n = 1'b1;
node_id_t node_id;
logic     trigger;
logic     env_idle;
logic     node_idle;
nx_msg_t  in_data [4];
logic     in_valid [4];
logic     in_ready [4];
nx_msg_t  out_data [4];
logic     out_valid [4];
logic     out_ready [4];

// Test closing towards the checker
logic test_done;
int   test_num;
int   chk_errors;
int   chk_checks;

// Checker mismatches plus assertion failures
int   all_errors;

// Per-face stimulus buffers
nx_msg_t send_buf [4][BUF_DEPTH];
int      send_head [4];
int      send_tail [4];
logic    taken [4];

logic [15:0] lfsr_q;
logic [39:0] recs [RECS];
logic        timed_out;

// ========================================
// DUT, checker and assertions
// ========================================

nx_node dut0 (
      .i_clk            ( clk       )
    , .i_arst_n         ( arst_n    )
    , .i_node_id        ( node_id   )
    , .i_trigger        ( trigger   )
    , .i_idle           ( env_idle  )
    , .o_idle           ( node_idle )
    , .i_inbound_data   ( in_data   )
    , .i_inbound_valid  ( in_valid  )
    , .o_inbound_ready  ( in_ready  )
    , .o_outbound_data  ( out_data  )
    , .o_outbound_valid ( out_valid )
    , .i_outbound_ready ( out_ready )
);

nx_node_checker u_checker (
      .i_clk       ( clk        )
    , .i_arst_n    ( arst_n     )
    , .i_env_idle  ( env_idle   )
    , .i_node_idle ( node_idle  )
    , .i_out_data  ( out_data   )
    , .i_out_valid ( out_valid  )
    , .i_out_ready ( out_ready  )
    , .i_test_done ( test_done  )
    , .i_test_num  ( test_num   )
    , .o_errors    ( chk_errors )
    , .o_checks    ( chk_checks )
);

bind nx_node nx_node_assert u_assert (
      .i_clk        ( i_clk            )
    , .i_arst_n     ( i_arst_n         )
    , .i_out_data   ( o_outbound_data  )
    , .i_out_valid  ( o_outbound_valid )
    , .i_out_ready  ( i_outbound_ready )
    , .i_in_ready   ( o_inbound_ready  )
    , .i_send_data  ( comb_data[1]     )
    , .i_send_valid ( comb_valid[1]    )
    , .i_send_ready ( comb_ready[1]    )
);

assign all_errors = chk_errors + dut0.u_assert.fail_count;

// ========================================
// Clock and back-pressure
// ========================================

initial begin
    forever begin
        #50 clk = ~clk;
    end
end

// Galois LFSR with taps for a maximal 16-bit sequence
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

// One LFSR bit per face per cycle
always @(negedge clk) begin
    for (int f = 0; f < 4; f++) begin
        out_ready[f] = lfsr_q[0];
        lfsr_q       = lfsr_next(lfsr_q);
    end
end

// ========================================
// Inbound feeders
// ========================================

always @(posedge clk) begin
    for (int f = 0; f < 4; f++) begin
        taken[f] <= in_valid[f] && in_ready[f];
    end
end

// Drop a taken message and present the next buffered one
always @(negedge clk) begin
    for (int f = 0; f < 4; f++) begin
        if (taken[f]) begin
            in_valid[f] = 1'b0;
        end
        if (!in_valid[f] && (send_head[f] != send_tail[f])) begin
            in_data[f]   = send_buf[f][send_head[f]];
            in_valid[f]  = 1'b1;
            send_head[f] = send_head[f] + 1;
        end
    end
end

task automatic push_send(input int face, input nx_msg_t msg);
    send_buf[face][send_tail[face]] = msg;
    send_tail[face]                 = send_tail[face] + 1;
endtask

task automatic pulse_trigger();
    @(negedge clk);
    trigger = 1'b1;
    @(negedge clk);
    trigger = 1'b0;
    @(posedge clk);
endtask

// Idle means nothing buffered, nothing presented and the node quiet
task automatic wait_idle();
    int   cycles;
    logic busy;
    cycles = 0;
    busy   = 1'b1;
    while (busy && !timed_out) begin
        @(posedge clk);
        busy = !node_idle;
        for (int f = 0; f < 4; f++) begin
            busy = busy || in_valid[f] || (send_head[f] != send_tail[f]);
        end
        cycles = cycles + 1;
        if (busy && (cycles >= IDLE_TIMEOUT)) begin
            $display("Timeout: node still busy after %0d cycles", IDLE_TIMEOUT);
            timed_out = 1'b1;
        end
    end
endtask

// Checker flushes what the test still owed
task automatic close_test(input int num, inout int seen_errors);
    int new_errors;
    @(negedge clk);
    test_num  = num;
    test_done = 1'b1;
    @(negedge clk);
    test_done  = 1'b0;
    new_errors = all_errors - seen_errors;
    $display("test %0d done, %0d errors", num, new_errors);
    seen_errors = all_errors;
endtask

// ========================================
// Main sequence
// ========================================

initial begin
    int         idx;
    int         test;
    int         seen_errors;
    logic [3:0] kind;
    node_id   = 8'h22;
    trigger   = 1'b0;
    env_idle  = 1'b0;
    test_done = 1'b0;
    test_num  = 0;
    timed_out = 1'b0;
    lfsr_q    = 16'd62;
    for (int f = 0; f < 4; f++) begin
        in_data[f]   = '0;
        in_valid[f]  = 1'b0;
        out_ready[f] = 1'b0;
        send_head[f] = 0;
        send_tail[f] = 0;
        taken[f]     = 1'b0;
    end
    for (int i = 0; i < RECS; i++) begin
        recs[i] = '0;
    end
    $readmemh("testbench/nx_node_patterns.hex", recs);
    // Reset goes low on the first falling edge
    @(negedge clk);
    arst_n = 1'b0;
    // Environment idle rises halfway through reset
    repeat (4) @(negedge clk);
    env_idle = 1'b1;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(posedge clk);
    $display("test 0 (reset) done, %0d errors", all_errors);
    seen_errors = all_errors;
    idx         = 0;
    test        = 1;
    while ((idx < RECS) && (recs[idx][39:36] != 4'h0) && !timed_out) begin
        kind = recs[idx][39:36];
        case (kind)
            4'h1: push_send(int'(recs[idx][33:32]), recs[idx][31:0]);
            4'h2: pulse_trigger();
            4'h3: wait_idle();
            4'h5: begin
                wait_idle();
                if (!timed_out) begin
                    close_test(test, seen_errors);
                    test = test + 1;
                end
            end
            // Expect records go to the checker
            default: ;
        endcase
        idx = idx + 1;
    end
    if (test == 1) begin
        $display("No pattern records were executed");
    end
    $display("tests %0d, checks %0d, errors %0d", test, chk_checks, all_errors);
    if (timed_out || (all_errors != 0) || (test == 1)) begin
        $display("Regression failed");
    end else begin
        $display("Regression passed");
    end
    $finish;
end

endmodule : tb_nx_node

// ==== nx_mesh.f ====
+incdir+include
src/nx_pkg.sv
src/nx_ram_if.sv
src/nx_ram.sv
src/nx_node_decoder.sv
src/nx_stream_arbiter.sv
src/nx_node_distributor.sv
src/nx_node_core.sv
src/nx_node.sv
testbench/nx_node_assert.sv
testbench/nx_node_checker.sv
testbench/tb_nx_node.sv

// ==== testbench/nx_node_patterns.hex ====
// Columns: kind (1 digit), face (1 digit), message (8 digits: target, cmd|addr, data)
// Kinds: 1 send on face, 2 trigger, 3 wait idle, 4 expect on face, 5 end of test, 0 end
1325431234
4125431234
3000000000
102541abcd
412541abcd
3000000000
11204abeef
43204abeef
1072000f0f
4272000f0f
12027fa5a5
40027fa5a5
5000000000
1023450001
1121460002
1232470003
1312480004
4123450001
4321460002
4232470003
4012480004
5000000000
1022449000
1022458123
1022000004
1022010005
1022028989
102203c000
3000000000
2000000000
4126491123
5000000000
1022460321
1022000006
1022014007
1022020007
1022039091
102204c000
3000000000
2000000000
4242510642
5000000000
1022810055
1122c10066
1225c30077
5000000000
0000000000
